//--- src/rv_macros.svh
// ==============================
// widths, opcodes, funct codes and reset PC for the RV32I core
// include this wherever a width or an encoding is needed
// ==============================
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN      32
`define REG_AW    5
`define RESET_PC  32'h0000_0000

// major opcodes
`define OPC_COMPUTE  7'b0110011
`define OPC_IMM      7'b0010011
`define OPC_BRANCH   7'b1100011
`define OPC_LUI      7'b0110111

// alu funct3
`define F3_ADD   3'b000
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SR    3'b101
`define F3_OR    3'b110
`define F3_AND   3'b111

// branch funct3
`define F3_BEQ   3'b000
`define F3_BNE   3'b001
`define F3_BLT   3'b100
`define F3_BGE   3'b101
`define F3_BLTU  3'b110
`define F3_BGEU  3'b111

`define F7_ALT   7'b0100000  // sub / sra

`endif

//--- src/rv_pkg.sv
// ==============================
// shared types of the pipeline: instruction views,
// alu op codes and the three stage registers
// ==============================
`include "rv_macros.svh"

package rv_pkg;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]        imm12;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } i_fmt_t;

  // branch offset bits are scattered over the word
  typedef struct packed {
    logic               imm_12;
    logic [5:0]         imm_10_5;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [3:0]         imm_4_1;
    logic               imm_11;
    logic [6:0]         opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    inst_u            inst;
  } if_id_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    logic [`XLEN-1:0]   imm;
    logic               use_imm;    // operand b from imm instead of rs2
    alu_op_e            alu_op;
    logic               is_branch;
    logic [2:0]         br_funct3;
    logic               wr_en;
  } id_ex_t;

  typedef struct packed {
    logic               valid;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   data;
  } ex_wb_t;

endpackage

//--- src/fetch_stage.sv
// ==============================
// fetch: program counter, stop on an all-zero word,
// branch redirect and the fetch/decode register
// ==============================
`timescale 1ns/1ps
`include "rv_macros.svh"

module fetch_stage
  import rv_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             redirect,
  input  logic [`XLEN-1:0] redirect_pc,
  output logic [`XLEN-1:0] imem_addr,
  input  inst_u            imem_data,
  output if_id_t           if_id,
  output logic             stopped
);

  logic [`XLEN-1:0] pc;
  logic             zero_word;

  assign imem_addr = pc;
  assign zero_word = (imem_data == '0);  // end of program marker

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc      <= `RESET_PC;
      stopped <= 1'b0;
      if_id   <= '0;
    end
    else if (redirect)
    begin
      // taken branch wins, even over a stop
      pc          <= redirect_pc;
      stopped     <= 1'b0;
      if_id.valid <= 1'b0;  // kill the wrong-path word
    end
    else if (stopped || zero_word)
    begin
      stopped     <= 1'b1;  // pc frozen
      if_id.valid <= 1'b0;
    end
    else
    begin
      pc         <= pc + 4;
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.inst  <= imem_data;
    end
  end

  // branch targets come from execute, so alignment is not local
  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
    else $error("fetch pc %h not word aligned", pc);

endmodule

//--- src/reg_file.sv
// ==============================
// register file, x1..x31, two read ports
// a same-cycle write is passed through to the readers
// ==============================
`timescale 1ns/1ps
`include "rv_macros.svh"

module reg_file
  import rv_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic [`REG_AW-1:0] rs1_addr,
  input  logic [`REG_AW-1:0] rs2_addr,
  output logic [`XLEN-1:0]   rs1_data,
  output logic [`XLEN-1:0]   rs2_data,
  input  ex_wb_t             wr
);

  logic [`XLEN-1:0] regs [1:31];  // x0 has no storage
  logic             hit1;
  logic             hit2;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr.valid && wr.rd != '0)
    begin
      regs[wr.rd] <= wr.data;
    end
  end

  // write-through covers the instruction two older
  assign hit1 = wr.valid && (wr.rd == rs1_addr);
  assign hit2 = wr.valid && (wr.rd == rs2_addr);

  assign rs1_data = (rs1_addr == '0) ? '0 : (hit1 ? wr.data : regs[rs1_addr]);
  assign rs2_data = (rs2_addr == '0) ? '0 : (hit2 ? wr.data : regs[rs2_addr]);

  // decode is expected to drop writes to x0 before they get here
  a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
    wr.valid |-> wr.rd != '0)
    else $error("write to x0 reached the register file");

endmodule

//--- src/decode_stage.sv
// ==============================
// decode: field split, immediates, alu control,
// register read and the decode/execute register
// ==============================
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage
  import rv_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  if_id_t             if_id,
  input  logic               flush,
  output logic [`REG_AW-1:0] rs1_addr,
  output logic [`REG_AW-1:0] rs2_addr,
  input  logic [`XLEN-1:0]   rs1_data,
  input  logic [`XLEN-1:0]   rs2_data,
  output id_ex_t             id_ex,
  output logic               empty
);

  inst_u            inst;
  logic [2:0]       f3;
  logic             alt;     // funct7 selects sub / sra
  logic             known;
  logic [`XLEN-1:0] imm_i, imm_sh, imm_b, imm_u;
  id_ex_t           nxt;

  // funct3 to alu op, sub only exists in the register form
  function automatic alu_op_e alu_sel(input logic [2:0] f, input logic a, input logic sub_ok);
    alu_op_e op;
    case (f)
      `F3_ADD:  op = (a && sub_ok) ? ALU_SUB : ALU_ADD;
      `F3_SLL:  op = ALU_SLL;
      `F3_SLT:  op = ALU_SLT;
      `F3_SLTU: op = ALU_SLTU;
      `F3_XOR:  op = ALU_XOR;
      `F3_SR:   op = a ? ALU_SRA : ALU_SRL;
      `F3_OR:   op = ALU_OR;
      default:  op = ALU_AND;
    endcase
    return op;
  endfunction

  assign inst     = if_id.inst;
  assign f3       = inst.r_fmt.funct3;
  assign alt      = (inst.r_fmt.funct7 == `F7_ALT);
  assign rs1_addr = inst.r_fmt.rs1;
  assign rs2_addr = inst.r_fmt.rs2;

  assign imm_i  = {{(`XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
  assign imm_sh = {{(`XLEN-5){1'b0}}, inst.r_fmt.rs2};  // shamt sits in the rs2 field
  assign imm_b  = {{(`XLEN-12){inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                   inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u  = {inst.i_fmt.imm12, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'b0};

  always_comb
  begin
    nxt           = '0;
    known         = 1'b1;
    nxt.pc        = if_id.pc;
    nxt.rs1       = inst.r_fmt.rs1;
    nxt.rs2       = inst.r_fmt.rs2;
    nxt.rd        = inst.r_fmt.rd;
    nxt.rs1_val   = rs1_data;
    nxt.rs2_val   = rs2_data;
    nxt.br_funct3 = f3;
    case (inst.r_fmt.opcode)
      `OPC_COMPUTE: nxt.alu_op = alu_sel(f3, alt, 1'b1);
      `OPC_IMM:
      begin
        nxt.use_imm = 1'b1;
        nxt.imm     = (f3 == `F3_SLL || f3 == `F3_SR) ? imm_sh : imm_i;
        nxt.alu_op  = alu_sel(f3, alt, 1'b0);
      end
      `OPC_LUI:
      begin
        nxt.use_imm = 1'b1;
        nxt.imm     = imm_u;
        nxt.alu_op  = ALU_PASS_B;
      end
      `OPC_BRANCH:
      begin
        nxt.is_branch = 1'b1;
        nxt.imm       = imm_b;
      end
      default: known = 1'b0;  // unsupported, becomes a bubble
    endcase
    nxt.wr_en = !nxt.is_branch && (inst.r_fmt.rd != '0);
    nxt.valid = if_id.valid && known;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      id_ex <= '0;
    else
    begin
      id_ex <= nxt;
      if (flush)
        id_ex.valid <= 1'b0;  // wrong path behind a taken branch
    end
  end

  assign empty = !if_id.valid;

endmodule

//--- src/alu.sv
// ==============================
// combinational RV32I alu
// arithmetic, logic, shifts, compares and pass-through of b
// ==============================
`timescale 1ns/1ps
`include "rv_macros.svh"

module alu
  import rv_pkg::*;
(
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  alu_op_e          op,
  output logic [`XLEN-1:0] y
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];  // only the low five bits count
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb
  begin
    case (op)
      ALU_ADD:    y = a + b;
      ALU_SUB:    y = a - b;
      ALU_SLL:    y = a << shamt;
      ALU_SLT:    y = {{(`XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   y = {{(`XLEN-1){1'b0}}, lt_u};
      ALU_XOR:    y = a ^ b;
      ALU_SRL:    y = a >> shamt;
      ALU_SRA:    y = $unsigned($signed(a) >>> shamt);  // sign fill
      ALU_OR:     y = a | b;
      ALU_AND:    y = a & b;
      ALU_PASS_B: y = b;  // lui
      default:    y = '0;
    endcase
  end

endmodule

//--- src/execute_stage.sv
// ==============================
// execute: forwarding from the previous result, alu,
// branch resolution and the execute/writeback register
// ==============================
`timescale 1ns/1ps
`include "rv_macros.svh"

module execute_stage
  import rv_pkg::*;
(
  input  logic             clk,
  input  logic             arst_n,
  input  id_ex_t           id_ex,
  output logic             redirect,
  output logic [`XLEN-1:0] redirect_pc,
  output ex_wb_t           ex_wb,
  output logic             empty
);

  logic [`XLEN-1:0] opa;
  logic [`XLEN-1:0] fwd_b;
  logic [`XLEN-1:0] opb;
  logic [`XLEN-1:0] alu_y;
  logic             take;

  // bypass from the instruction one older
  assign opa   = (ex_wb.valid && ex_wb.rd == id_ex.rs1) ? ex_wb.data : id_ex.rs1_val;
  assign fwd_b = (ex_wb.valid && ex_wb.rd == id_ex.rs2) ? ex_wb.data : id_ex.rs2_val;
  assign opb   = id_ex.use_imm ? id_ex.imm : fwd_b;

  alu u_alu (
    .a  (opa),
    .b  (opb),
    .op (id_ex.alu_op),
    .y  (alu_y)
  );

  // branch condition on the forwarded register values
  always_comb
  begin
    case (id_ex.br_funct3)
      `F3_BEQ:  take = (opa == fwd_b);
      `F3_BNE:  take = (opa != fwd_b);
      `F3_BLT:  take = $signed(opa) < $signed(fwd_b);
      `F3_BGE:  take = $signed(opa) >= $signed(fwd_b);
      `F3_BLTU: take = opa < fwd_b;
      `F3_BGEU: take = opa >= fwd_b;
      default:  take = 1'b0;
    endcase
  end

  // predicted not-taken, so only a taken branch redirects
  assign redirect    = id_ex.valid && id_ex.is_branch && take;
  assign redirect_pc = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ex_wb <= '0;
    else
    begin
      ex_wb.valid <= id_ex.valid && id_ex.wr_en;
      ex_wb.rd    <= id_ex.rd;
      ex_wb.data  <= alu_y;
    end
  end

  assign empty = !id_ex.valid;

  // the flush must have emptied the slot behind a taken branch
  a_redirect_flush: assert property (@(posedge clk) disable iff (!arst_n)
    redirect |=> !id_ex.valid)
    else $error("slot behind a taken branch was not flushed");

endmodule

//--- src/rv_core.sv
// ==============================
// four-stage RV32I core top: fetch, decode, execute, writeback
// instruction memory sits outside, writes leave on the wb port
// ==============================
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  output logic [`XLEN-1:0]   imem_addr,
  input  logic [`XLEN-1:0]   imem_data,
  output logic               wb_valid,
  output logic [`REG_AW-1:0] wb_rd,
  output logic [`XLEN-1:0]   wb_data,
  output logic               halt
);

  if_id_t             if_id;
  id_ex_t             id_ex;
  ex_wb_t             ex_wb;
  logic               redirect;
  logic [`XLEN-1:0]   redirect_pc;
  logic               stopped;
  logic               dec_empty;
  logic               ex_empty;
  logic [`REG_AW-1:0] rs1_addr, rs2_addr;
  logic [`XLEN-1:0]   rs1_data, rs2_data;

  fetch_stage u_fetch (
    .clk, .arst_n, .redirect, .redirect_pc,
    .imem_addr, .imem_data, .if_id, .stopped
  );

  reg_file u_rf (
    .clk, .arst_n, .rs1_addr, .rs2_addr,
    .rs1_data, .rs2_data, .wr (ex_wb)
  );

  decode_stage u_decode (
    .clk, .arst_n, .if_id, .flush (redirect),
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .id_ex, .empty (dec_empty)
  );

  execute_stage u_execute (
    .clk, .arst_n, .id_ex, .redirect, .redirect_pc,
    .ex_wb, .empty (ex_empty)
  );

  assign wb_valid = ex_wb.valid;
  assign wb_rd    = ex_wb.rd;
  assign wb_data  = ex_wb.data;

  // drained: fetch stopped and no stage holds work
  assign halt = stopped && dec_empty && ex_empty && !ex_wb.valid;

endmodule

//--- test/tb_rv_core.sv
// ==============================
// testbench for the four-stage RV32I core
// runs a table of programs and checks every writeback against hand-worked values
// ==============================
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_core;

  localparam int NPROG = 4;
  localparam int MAXW  = 64;
  localparam int MAXE  = 32;

  logic        clk;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        halt;

  logic [31:0] imem [0:MAXW-1];
  logic [31:0] prog_words [NPROG][MAXW];
  int          prog_len [NPROG];
  logic [4:0]  exp_rd [NPROG][MAXE];
  logic [31:0] exp_data [NPROG][MAXE];
  int          exp_len [NPROG];
  int          budget;
  int          idx;

  rv_core u_dut (
    .clk, .arst_n, .imem_addr, .imem_data,
    .wb_valid, .wb_rd, .wb_data, .halt
  );

  // words past the array read as zero, which is the stop marker
  assign imem_data = (imem_addr[31:8] == '0) ? imem[imem_addr[7:2]] : 32'h0;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_COMPUTE};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `OPC_IMM};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, `OPC_LUI};
  endfunction

  // offset is in bytes, bit 0 is dropped by the format
  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  task automatic add_word(input int p, input logic [31:0] w);
    prog_words[p][prog_len[p]] = w;
    prog_len[p]++;
  endtask

  task automatic add_expect(input int p, input logic [4:0] rd, input logic [31:0] d);
    exp_rd[p][exp_len[p]]   = rd;
    exp_data[p][exp_len[p]] = d;
    exp_len[p]++;
  endtask

  // one word that must show up as a write of rd with value d
  task automatic add_op(input int p, input logic [31:0] w, input logic [4:0] rd,
                        input logic [31:0] d);
    add_word(p, w);
    add_expect(p, rd, d);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic build_table();
    // program 0: register-register ops
    add_op(0, i_type(12'hFF9, 0, `F3_ADD, 1), 1, 32'hFFFF_FFF9);
    add_op(0, i_type(12'h003, 0, `F3_ADD, 2), 2, 32'h0000_0003);
    add_op(0, r_type(7'h00, 2, 1, `F3_ADD, 3), 3, 32'hFFFF_FFFC);
    add_op(0, r_type(`F7_ALT, 1, 2, `F3_ADD, 4), 4, 32'h0000_000A);
    add_op(0, r_type(7'h00, 2, 2, `F3_SLL, 5), 5, 32'h0000_0018);
    add_op(0, r_type(7'h00, 2, 1, `F3_SLT, 6), 6, 32'h0000_0001);
    add_op(0, r_type(7'h00, 2, 1, `F3_SLTU, 7), 7, 32'h0000_0000);
    add_op(0, r_type(7'h00, 2, 1, `F3_XOR, 8), 8, 32'hFFFF_FFFA);
    add_op(0, r_type(7'h00, 2, 1, `F3_SR, 9), 9, 32'h1FFF_FFFF);
    add_op(0, r_type(`F7_ALT, 2, 1, `F3_SR, 10), 10, 32'hFFFF_FFFF);
    add_op(0, r_type(7'h00, 2, 1, `F3_OR, 11), 11, 32'hFFFF_FFFB);
    add_op(0, r_type(7'h00, 2, 1, `F3_AND, 12), 12, 32'h0000_0001);
    // program 1: immediate ops and lui
    add_op(1, i_type(12'hF9C, 0, `F3_ADD, 1), 1, 32'hFFFF_FF9C);
    add_op(1, i_type(12'hF9D, 1, `F3_SLT, 2), 2, 32'h0000_0001);
    add_op(1, i_type(12'h005, 1, `F3_SLTU, 3), 3, 32'h0000_0000);
    add_op(1, i_type(12'h00F, 1, `F3_XOR, 4), 4, 32'hFFFF_FF93);
    add_op(1, i_type(12'h7FF, 0, `F3_OR, 5), 5, 32'h0000_07FF);
    add_op(1, i_type(12'hFF0, 1, `F3_AND, 6), 6, 32'hFFFF_FF90);
    add_op(1, i_type(12'h004, 5, `F3_SLL, 7), 7, 32'h0000_7FF0);
    add_op(1, i_type(12'h402, 1, `F3_SR, 8), 8, 32'hFFFF_FFE7);  // srai
    add_op(1, i_type(12'h01C, 1, `F3_SR, 9), 9, 32'h0000_000F);
    add_op(1, lui(10, 20'hABCDE), 10, 32'hABCD_E000);
    add_op(1, lui(11, 20'h80000), 11, 32'h8000_0000);
    add_word(1, i_type(12'h005, 1, `F3_ADD, 0));  // x0 target, never seen
    // program 2: dependency chain, one and two apart
    add_op(2, i_type(12'h005, 0, `F3_ADD, 1), 1, 32'd5);
    add_op(2, i_type(12'h001, 1, `F3_ADD, 2), 2, 32'd6);
    add_op(2, r_type(7'h00, 2, 1, `F3_ADD, 3), 3, 32'd11);
    add_op(2, r_type(`F7_ALT, 1, 3, `F3_ADD, 4), 4, 32'd6);
    add_op(2, r_type(7'h00, 3, 4, `F3_ADD, 5), 5, 32'd17);
    add_op(2, r_type(7'h00, 5, 5, `F3_ADD, 5), 5, 32'd34);
    add_op(2, i_type(12'h002, 5, `F3_SLL, 6), 6, 32'd136);
    add_op(2, r_type(7'h00, 4, 6, `F3_XOR, 7), 7, 32'd142);
    add_word(2, i_type(12'h009, 0, `F3_ADD, 0));  // must not forward into x0
    add_op(2, r_type(7'h00, 7, 0, `F3_ADD, 8), 8, 32'd142);
    // program 3: branches, x1 = -2, x2 = 3
    add_op(3, i_type(12'hFFE, 0, `F3_ADD, 1), 1, 32'hFFFF_FFFE);
    add_op(3, i_type(12'h003, 0, `F3_ADD, 2), 2, 32'h0000_0003);
    add_taken(`F3_BEQ, 2, 2, 12'h011);
    add_taken(`F3_BNE, 1, 2, 12'h012);
    add_taken(`F3_BLT, 1, 2, 12'h013);
    add_taken(`F3_BGE, 2, 1, 12'h014);
    add_taken(`F3_BLTU, 2, 1, 12'h015);
    add_taken(`F3_BGEU, 1, 2, 12'h016);
    add_not_taken(`F3_BEQ, 1, 2, 12'h021);
    add_not_taken(`F3_BNE, 2, 2, 12'h022);
    add_not_taken(`F3_BLT, 2, 1, 12'h023);
    add_not_taken(`F3_BGE, 1, 2, 12'h024);
    add_not_taken(`F3_BLTU, 1, 2, 12'h025);
    add_not_taken(`F3_BGEU, 2, 1, 12'h026);
  endtask

  // branch over two writes of x10, then land on a write of x11
  task automatic add_taken(input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [11:0] mark);
    add_word(3, b_type(f3, rs1, rs2, 13'd12));
    add_word(3, i_type(12'h001, 0, `F3_ADD, 10));
    add_word(3, i_type(12'h002, 0, `F3_ADD, 10));
    add_op(3, i_type(mark, 0, `F3_ADD, 11), 11, {20'h0, mark});
  endtask

  // fall through into writes of x12 and x13
  task automatic add_not_taken(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [11:0] mark);
    add_word(3, b_type(f3, rs1, rs2, 13'd12));
    add_op(3, i_type(mark, 0, `F3_ADD, 12), 12, {20'h0, mark});
    add_op(3, i_type(mark, 0, `F3_ADD, 13), 13, {20'h0, mark});
  endtask

  initial
  begin
    arst_n    = 1'b0;
    budget    = 0;
    for (int p = 0; p < NPROG; p++)
    begin
      prog_len[p] = 0;
      exp_len[p]  = 0;
    end
    build_table();
    for (int p = 0; p < NPROG; p++)
      budget += 4 * prog_len[p] + 20 + 12;  // 12 covers the reset phase

    fork
      begin
        repeat (budget) @(posedge clk);
        $display("watchdog expired: the core did not halt in time");
        $display("test failed");
        $fatal(1);
      end
    join_none

    for (int p = 0; p < NPROG; p++)
    begin
      @(posedge clk);
      arst_n <= 1'b0;
      for (int a = 0; a < MAXW; a++)
        imem[a] <= (a < prog_len[p]) ? prog_words[p][a] : 32'h0;
      repeat (10)
      begin
        @(negedge clk);
        check_value("wb_valid in reset", {31'h0, wb_valid}, 32'h0);
        check_value("halt in reset", {31'h0, halt}, 32'h0);
        check_value("imem_addr in reset", imem_addr, `RESET_PC);
      end
      @(posedge clk);
      arst_n <= 1'b1;
      idx = 0;
      while (1)
      begin
        @(negedge clk);  // outputs settled between edges
        if (wb_valid)
        begin
          if (idx >= exp_len[p])
          begin
            $display("program %0d wrote x%0d but no more writes were expected", p, wb_rd);
            $display("test failed");
            $fatal(1);
          end
          check_value("wb_rd", {27'h0, wb_rd}, {27'h0, exp_rd[p][idx]});
          check_value("wb_data", wb_data, exp_data[p][idx]);
          idx++;
        end
        if (halt)
          break;
      end
      if (idx != exp_len[p])
      begin
        $display("program %0d halted after %0d of %0d writes", p, idx, exp_len[p]);
        $display("test failed");
        $fatal(1);
      end
    end

    $display("test passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+src
src/rv_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/alu.sv
src/execute_stage.sv
src/rv_core.sv
test/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; success only if the pass message shows up
verilator --binary -f verilog.f --top-module tb_rv_core -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "test passed" \
  && echo "simulation ok" \
  || { echo "simulation FAILED"; exit 1; }
